// ==== dv/bus85_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus85_params.svh"

module bus85_checker (
	input  wire                               clk,
	input  wire                               rst,
	// DUT pins
	input  wire                               i_ale,
	input  wire                               i_rd_n,
	input  wire                               i_wr_n,
	input  wire                               i_inta_n,
	input  wire                               i_iom_n,
	input  wire                               i_s1,
	input  wire                               i_s0,
	input  wire bus85_cycle_pkg::data_t       i_addr_hi,
	input  wire bus85_cycle_pkg::data_t       i_ad,
	input  wire                               i_ad_oe,
	input  wire                               i_done,
	input  wire bus85_cycle_pkg::data_t       i_rdata,
	input  wire                               i_int_req,
	input  wire bus85_intr_pkg::int_vec_t     i_int_vec,
	input  wire bus85_intr_pkg::rim_t         i_rim,
	input  wire                               i_sod,
	// expectations from the trace
	input  wire                               i_exp_push,
	input  wire bus85_cycle_pkg::cycle_kind_e i_exp_kind,
	input  wire bus85_cycle_pkg::addr_t       i_exp_addr,
	input  wire bus85_cycle_pkg::data_t       i_exp_wdata,
	input  wire integer                       i_exp_waits,
	input  wire bus85_cycle_pkg::data_t       i_exp_rbyte,
	input  wire                               i_int_chk,
	input  wire                               i_exp_req,
	input  wire bus85_intr_pkg::int_vec_t     i_exp_vec,
	input  wire bus85_intr_pkg::rim_t         i_exp_rim,
	input  wire                               i_exp_sod,
	output int                                o_errors,
	output int                                o_done_cnt
);
	import bus85_cycle_pkg::*;

	cycle_kind_e kind_q[$];
	addr_t       addr_q[$];
	data_t       wdata_q[$];
	int          waits_q[$];
	data_t       rbyte_q[$];

	cycle_kind_e cur_kind;
	addr_t       cur_addr;
	data_t       cur_wdata;
	int          cur_waits;
	data_t       cur_rbyte;
	stactl_t     code;
	logic        active;
	logic        rd_pending;
	int          strobe_cnt;

	// {inta_n, wr_n, rd_n, iom_n, s1, s0} per kind
	function automatic stactl_t expected_code(input cycle_kind_e k);
		case (k)
			CYC_OF:  return 6'b110011;
			CYC_MR:  return 6'b110010;
			CYC_MW:  return 6'b101001;
			CYC_DR:  return 6'b110110;
			CYC_DW:  return 6'b101101;
			CYC_INA: return 6'b011111;
			default: return 6'b111111;
		endcase
	endfunction

	function automatic logic is_write(input cycle_kind_e k);
		return (k == CYC_MW) || (k == CYC_DW);
	endfunction

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			o_errors++;
			$display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic compare_status;
		compare("o_iom_n", 16'(code[`BUS85_BIT_IOM]), 16'(i_iom_n));
		compare("o_s1", 16'(code[`BUS85_BIT_S1]), 16'(i_s1));
		compare("o_s0", 16'(code[`BUS85_BIT_S0]), 16'(i_s0));
	endtask

	// ----------------------------------------
	// sampled on the rising edge
	// ----------------------------------------

	always @(posedge clk) begin
		if (rst) begin
			o_errors   = 0;
			o_done_cnt = 0;
			active     = 1'b0;
			rd_pending = 1'b0;
		end else begin
			if (rd_pending) begin // o_rdata loads at the end of T3
				compare("o_rdata", 16'(cur_rbyte), 16'(i_rdata));
				rd_pending = 1'b0;
			end
			if (i_exp_push) begin
				kind_q.push_back(i_exp_kind);
				addr_q.push_back(i_exp_addr);
				wdata_q.push_back(i_exp_wdata);
				waits_q.push_back(i_exp_waits);
				rbyte_q.push_back(i_exp_rbyte);
			end
			if (i_ale) begin
				if (kind_q.size() == 0) begin
					o_errors++;
					$display("a bus cycle started with no request outstanding at %0t", $time);
				end else begin
					cur_kind   = kind_q.pop_front();
					cur_addr   = addr_q.pop_front();
					cur_wdata  = wdata_q.pop_front();
					cur_waits  = waits_q.pop_front();
					cur_rbyte  = rbyte_q.pop_front();
					code       = expected_code(cur_kind);
					active     = 1'b1;
					strobe_cnt = 0;
					compare("o_ad", 16'(cur_addr[7:0]), 16'(i_ad));
					compare("o_ad_oe", 16'h1, 16'(i_ad_oe));
					compare("o_addr_hi", 16'(cur_addr[15:8]), 16'(i_addr_hi));
					compare_status();
				end
			end else if (active) begin
				if (!i_rd_n || !i_wr_n || !i_inta_n) begin
					strobe_cnt++;
					compare("o_rd_n", 16'(code[`BUS85_BIT_RD]), 16'(i_rd_n));
					compare("o_wr_n", 16'(code[`BUS85_BIT_WR]), 16'(i_wr_n));
					compare("o_inta_n", 16'(code[`BUS85_BIT_INTA]), 16'(i_inta_n));
					compare("o_ad_oe", 16'(is_write(cur_kind)), 16'(i_ad_oe));
					compare("o_addr_hi", 16'(cur_addr[15:8]), 16'(i_addr_hi));
					compare_status();
					if (is_write(cur_kind))
						compare("o_ad", 16'(cur_wdata), 16'(i_ad));
				end
				if (i_done) begin
					compare("strobe_cycles", 16'(cur_waits + 2), 16'(strobe_cnt));
					rd_pending = !is_write(cur_kind);
					active     = 1'b0;
					o_done_cnt++;
				end
			end else if (i_done) begin
				o_errors++;
				$display("o_done pulsed outside a bus cycle at %0t", $time);
			end
			if (i_int_chk) begin
				compare("o_int_req", 16'(i_exp_req), 16'(i_int_req));
				compare("o_int_vec", 16'(i_exp_vec), 16'(i_int_vec));
				compare("o_rim", 16'(i_exp_rim), 16'(i_rim));
				compare("o_sod", 16'(i_exp_sod), 16'(i_sod));
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/bus85_trace.txt ====
# B kind(0 OF,1 MR,2 MW,3 DR,4 DW,5 INA) addr wdata waits rbyte
# I simwr simdata ei di trap r75 r65 r55 sid | exp_req exp_vec exp_rim exp_sod
B 0 1234 00 0 3E
B 1 2345 00 1 A5
B 2 3456 5A 0 00
B 3 0080 00 2 C3
B 4 0081 99 1 00
B 5 0000 00 0 FF
B 0 ABCD 00 3 76
B 2 FFFE 11 0 00
B 1 8001 00 0 E7
I 0 00 0 0 0 0 0 0 0 0 00 07 0
I 1 08 0 0 0 0 0 0 1 0 00 80 0
I 0 00 1 0 0 0 0 1 0 1 2C 18 0
I 0 00 0 0 0 0 1 1 0 1 34 38 0
I 0 00 0 0 0 1 1 1 0 1 3C 78 0
I 1 0C 0 0 0 1 1 1 0 1 34 3C 0
I 0 00 0 0 1 1 1 1 0 1 24 3C 0
I 1 C8 0 0 0 1 1 1 0 1 3C 78 1
I 1 18 0 0 0 1 1 1 0 1 34 38 1
I 0 00 0 1 0 1 1 1 0 0 00 00 1
I 0 00 1 0 0 0 0 0 0 0 00 08 1
I 0 00 0 0 0 1 0 0 0 1 3C 48 1
B 5 0038 00 1 FF
I 0 00 0 0 0 1 0 0 1 0 00 80 1

// ==== dv/tb_bus85.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus85_params.svh"

module tb_bus85;
	import bus85_cycle_pkg::*;
	import bus85_intr_pkg::*;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic        i_req = 1'b0;
	cycle_kind_e i_kind = CYC_OF;
	addr_t       i_addr = '0;
	data_t       i_wdata = '0;
	logic        i_ready = 1'b1;
	data_t       i_ad = '0;
	logic        i_sim_wr = 1'b0;
	data_t       i_sim_data = '0;
	logic        i_ei = 1'b0;
	logic        i_di = 1'b0;
	logic        i_trap = 1'b0;
	logic        i_rst75 = 1'b0;
	logic        i_rst65 = 1'b0;
	logic        i_rst55 = 1'b0;
	logic        i_sid = 1'b0;

	wire         o_busy, o_done, o_ad_oe, o_ale, o_rd_n, o_wr_n, o_inta_n;
	wire         o_iom_n, o_s1, o_s0, o_int_req, o_sod;
	data_t       o_rdata, o_ad, o_addr_hi;
	int_vec_t    o_int_vec;
	rim_t        o_rim;

	// expectation lines into the checker
	logic        exp_push = 1'b0;
	int          exp_waits = 0;
	data_t       exp_rbyte = '0;
	logic        int_chk = 1'b0;
	logic        exp_req = 1'b0;
	int_vec_t    exp_vec = '0;
	rim_t        exp_rim = '0;
	logic        exp_sod = 1'b0;
	int          chk_errors;
	int          done_cnt;

	int          tb_errors = 0;
	int          issued = 0;
	logic        abort = 1'b0;
	int          wait_q[$]; // READY model queues in request order
	data_t       rbyte_q[$];
	int          waits_left = 0;

	initial begin
		forever #5 clk = ~clk;
	end

	bus85_top UUT (
		.clk(clk), .rst(rst),
		.i_req(i_req), .i_kind(i_kind), .i_addr(i_addr), .i_wdata(i_wdata),
		.o_busy(o_busy), .o_done(o_done), .o_rdata(o_rdata),
		.i_ready(i_ready), .i_ad(i_ad), .o_ad(o_ad), .o_ad_oe(o_ad_oe),
		.o_addr_hi(o_addr_hi), .o_ale(o_ale), .o_rd_n(o_rd_n), .o_wr_n(o_wr_n),
		.o_inta_n(o_inta_n), .o_iom_n(o_iom_n), .o_s1(o_s1), .o_s0(o_s0),
		.i_sim_wr(i_sim_wr), .i_sim_data(i_sim_data), .i_ei(i_ei), .i_di(i_di),
		.i_trap(i_trap), .i_rst75(i_rst75), .i_rst65(i_rst65), .i_rst55(i_rst55),
		.i_sid(i_sid), .o_int_req(o_int_req), .o_int_vec(o_int_vec),
		.o_rim(o_rim), .o_sod(o_sod)
	);

	bus85_checker u_chk (
		.clk(clk), .rst(rst),
		.i_ale(o_ale), .i_rd_n(o_rd_n), .i_wr_n(o_wr_n), .i_inta_n(o_inta_n),
		.i_iom_n(o_iom_n), .i_s1(o_s1), .i_s0(o_s0), .i_addr_hi(o_addr_hi),
		.i_ad(o_ad), .i_ad_oe(o_ad_oe), .i_done(o_done), .i_rdata(o_rdata),
		.i_int_req(o_int_req), .i_int_vec(o_int_vec), .i_rim(o_rim), .i_sod(o_sod),
		.i_exp_push(exp_push), .i_exp_kind(i_kind), .i_exp_addr(i_addr),
		.i_exp_wdata(i_wdata), .i_exp_waits(exp_waits), .i_exp_rbyte(exp_rbyte),
		.i_int_chk(int_chk), .i_exp_req(exp_req), .i_exp_vec(exp_vec),
		.i_exp_rim(exp_rim), .i_exp_sod(exp_sod),
		.o_errors(chk_errors), .o_done_cnt(done_cnt)
	);

	// ----------------------------------------
	// memory and READY model
	// ----------------------------------------

	always @(negedge clk) begin
		if (o_ale) begin // a new cycle fetches its wait count and read byte
			if (wait_q.size() == 0) begin
				waits_left = 0;
			end else begin
				waits_left = wait_q.pop_front();
				i_ad       = rbyte_q.pop_front();
			end
			i_ready = 1'b1;
		end else if ((!o_rd_n || !o_wr_n || !o_inta_n) && waits_left > 0) begin
			i_ready    = 1'b0;
			waits_left = waits_left - 1;
		end else begin
			i_ready = 1'b1;
		end
	end

	task automatic wait_not_busy;
		int n;
		for (n = 0; n < 100 && o_busy; n++)
			@(negedge clk);
		if (o_busy) begin
			tb_errors++;
			abort = 1'b1;
			$display("timeout waiting for o_busy to fall");
		end
	endtask

	task automatic drain_bus;
		int n;
		for (n = 0; n < 400 && done_cnt != issued; n++)
			@(negedge clk);
		if (done_cnt != issued) begin
			tb_errors++;
			abort = 1'b1;
			$display("timeout, %0d of %0d bus cycles completed", done_cnt, issued);
		end
		@(negedge clk); // lets the read byte check run
	endtask

	task automatic issue_bus(input int k, input addr_t a, input data_t wd,
			input int waits, input data_t rb);
		repeat ($urandom % 3) @(negedge clk); // random gap
		wait_not_busy();
		if (!abort) begin
			i_req     = 1'b1;
			i_kind    = cycle_kind_e'(k[2:0]);
			i_addr    = a;
			i_wdata   = wd;
			exp_push  = 1'b1;
			exp_waits = waits;
			exp_rbyte = rb;
			wait_q.push_back(waits);
			rbyte_q.push_back(rb);
			issued++;
			@(negedge clk);
			i_req    = 1'b0;
			exp_push = 1'b0;
		end
	endtask

	task automatic apply_intr(input logic [7:0] f[13]);
		drain_bus();
		i_sim_wr   = f[0][0];
		i_sim_data = f[1];
		i_ei       = f[2][0];
		i_di       = f[3][0];
		i_trap     = f[4][0];
		i_rst75    = f[5][0];
		i_rst65    = f[6][0];
		i_rst55    = f[7][0];
		i_sid      = f[8][0];
		@(negedge clk);
		i_sim_wr = 1'b0;
		i_ei     = 1'b0;
		i_di     = 1'b0;
		repeat (4) @(negedge clk); // synchronizer and edge latch settle
		int_chk = 1'b1;
		exp_req = f[9][0];
		exp_vec = f[10];
		exp_rim = f[11];
		exp_sod = f[12][0];
		@(negedge clk);
		int_chk = 1'b0;
	endtask

	// ----------------------------------------
	// trace reader
	// ----------------------------------------

	initial begin
		int fd;
		int c;
		int n;
		int k;
		int waits;
		logic [15:0] a;
		logic [7:0] wd;
		logic [7:0] rb;
		logic [7:0] f[13];
		logic [8*160-1:0] line_buf;
		void'($urandom(33383));
		repeat (5) @(negedge clk);
		rst = 1'b0;
		fd = $fopen("dv/bus85_trace.txt", "r");
		if (fd == 0) begin
			tb_errors++;
			$display("trace file dv/bus85_trace.txt could not be opened");
		end else begin
			while (!abort) begin
				c = $fgetc(fd);
				if (c < 0)
					break;
				if (c == 35) begin // comment line
					n = $fgets(line_buf, fd);
				end else if (c == 66) begin // B
					n = $fscanf(fd, " %h %h %h %d %h", k, a, wd, waits, rb);
					if (n != 5) begin
						tb_errors++;
						abort = 1'b1;
						$display("a bus line of the trace file could not be parsed");
					end else begin
						issue_bus(k, a, wd, waits, rb);
					end
				end else if (c == 73) begin // I
					n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6],
						f[7], f[8], f[9], f[10], f[11], f[12]);
					if (n != 13) begin
						tb_errors++;
						abort = 1'b1;
						$display("an interrupt line of the trace file could not be parsed");
					end else begin
						apply_intr(f);
					end
				end
			end
			$fclose(fd);
			if (!abort)
				drain_bus();
		end
		repeat (3) @(negedge clk);
		$display("errors: checker %0d, testbench %0d, bus cycles %0d", chk_errors,
			tb_errors, done_cnt);
		if (chk_errors == 0 && tb_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/bus85_cycle_pkg.sv
hw/bus85_intr_pkg.sv
hw/cycle_decode.sv
hw/tstate_seq.sv
hw/bus_pin_drive.sv
hw/intr_ctrl.sv
hw/bus85_top.sv
dv/bus85_checker.sv
dv/tb_bus85.sv

// ==== hw/bus85_cycle_pkg.sv ====
`default_nettype none

`include "bus85_params.svh"

package bus85_cycle_pkg;

	typedef logic [`BUS85_ADDR_W-1:0] addr_t;
	typedef logic [`BUS85_DATA_W-1:0] data_t;

	// {inta_n, wr_n, rd_n, iom_n, s1, s0}
	typedef logic [`BUS85_STACTL_W-1:0] stactl_t;

	// machine cycle kinds the host may ask for
	typedef enum logic [2:0] {
		CYC_OF  = 3'd0, // opcode fetch
		CYC_MR  = 3'd1,
		CYC_MW  = 3'd2,
		CYC_DR  = 3'd3, // device read
		CYC_DW  = 3'd4,
		CYC_INA = 3'd5  // interrupt acknowledge
	} cycle_kind_e;

	// one-hot bus states
	typedef enum logic [`BUS85_TSTATE_CNT-1:0] {
		TS_IDLE = 6'b000001,
		TS_T1   = 6'b000010,
		TS_T2   = 6'b000100,
		TS_TW   = 6'b001000,
		TS_T3   = 6'b010000,
		TS_T4   = 6'b100000 // opcode fetch only
	} tstate_e;

endpackage

`default_nettype wire

// ==== hw/bus85_intr_pkg.sv ====
`default_nettype none

`include "bus85_params.svh"

package bus85_intr_pkg;

	typedef logic [`BUS85_DATA_W-1:0] int_vec_t; // restart address

	// {sid, ip75, ip65, ip55, ie, m75, m65, m55}
	typedef logic [`BUS85_DATA_W-1:0] rim_t;

	// winner of the priority chain
	typedef enum logic [2:0] {
		LVL_NONE = 3'd0,
		LVL_R55  = 3'd1,
		LVL_R65  = 3'd2,
		LVL_R75  = 3'd3,
		LVL_TRAP = 3'd4
	} int_level_e;

endpackage

`default_nettype wire

// ==== hw/bus85_params.svh ====
`ifndef BUS85_PARAMS_SVH
`define BUS85_PARAMS_SVH

// bus widths
`define BUS85_ADDR_W      16
`define BUS85_DATA_W      8
`define BUS85_STACTL_W    6
`define BUS85_TSTATE_CNT  6   // idle, t1, t2, tw, t3, t4

// positions inside the status and control code
`define BUS85_BIT_S0      0
`define BUS85_BIT_S1      1
`define BUS85_BIT_IOM     2
`define BUS85_BIT_RD      3
`define BUS85_BIT_WR      4
`define BUS85_BIT_INTA    5

// restart addresses
`define BUS85_VEC_TRAP    8'h24
`define BUS85_VEC_R75     8'h3C
`define BUS85_VEC_R65     8'h34
`define BUS85_VEC_R55     8'h2C

`endif

// ==== hw/bus85_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus85_top (
	input  wire                               clk,
	input  wire                               rst,
	// host request side
	input  wire                               i_req,
	input  wire bus85_cycle_pkg::cycle_kind_e i_kind,
	input  wire bus85_cycle_pkg::addr_t       i_addr,
	input  wire bus85_cycle_pkg::data_t       i_wdata,
	output logic                              o_busy,
	output logic                              o_done,
	output bus85_cycle_pkg::data_t            o_rdata,
	// bus pins
	input  wire                               i_ready,
	input  wire bus85_cycle_pkg::data_t       i_ad,
	output bus85_cycle_pkg::data_t            o_ad,
	output logic                              o_ad_oe,
	output bus85_cycle_pkg::data_t            o_addr_hi,
	output logic                              o_ale,
	output logic                              o_rd_n,
	output logic                              o_wr_n,
	output logic                              o_inta_n,
	output logic                              o_iom_n,
	output logic                              o_s1,
	output logic                              o_s0,
	// interrupt side
	input  wire                               i_sim_wr,
	input  wire bus85_cycle_pkg::data_t       i_sim_data,
	input  wire                               i_ei,
	input  wire                               i_di,
	input  wire                               i_trap,
	input  wire                               i_rst75,
	input  wire                               i_rst65,
	input  wire                               i_rst55,
	input  wire                               i_sid,
	output logic                              o_int_req,
	output bus85_intr_pkg::int_vec_t          o_int_vec,
	output bus85_intr_pkg::rim_t              o_rim,
	output logic                              o_sod
);
	import bus85_cycle_pkg::*;

	// decode to sequencer
	logic        dec_valid;
	cycle_kind_e dec_kind;
	stactl_t     dec_stactl;
	addr_t       dec_addr;
	data_t       dec_wdata;
	logic        seq_take;

	// sequencer to pins
	tstate_e     seq_state;
	stactl_t     seq_stactl;
	addr_t       seq_addr;
	data_t       seq_wdata;
	logic        seq_ack_done;

	// ----------------------------------------
	// bus pipeline
	// ----------------------------------------

	cycle_decode u_decode (
		.clk      (clk),
		.rst      (rst),
		.i_req    (i_req),
		.i_kind   (i_kind),
		.i_addr   (i_addr),
		.i_wdata  (i_wdata),
		.i_take   (seq_take),
		.o_valid  (dec_valid),
		.o_kind   (dec_kind),
		.o_stactl (dec_stactl),
		.o_addr   (dec_addr),
		.o_wdata  (dec_wdata),
		.o_busy   (o_busy)
	);

	tstate_seq u_seq (
		.clk        (clk),
		.rst        (rst),
		.i_valid    (dec_valid),
		.i_kind     (dec_kind),
		.i_stactl   (dec_stactl),
		.i_addr     (dec_addr),
		.i_wdata    (dec_wdata),
		.i_ready    (i_ready),
		.i_ad       (i_ad),
		.o_take     (seq_take),
		.o_state    (seq_state),
		.o_stactl   (seq_stactl),
		.o_addr     (seq_addr),
		.o_wdata    (seq_wdata),
		.o_done     (o_done),
		.o_rdata    (o_rdata),
		.o_ack_done (seq_ack_done)
	);

	bus_pin_drive u_pins (
		.clk       (clk),
		.rst       (rst),
		.i_state   (seq_state),
		.i_stactl  (seq_stactl),
		.i_addr    (seq_addr),
		.i_wdata   (seq_wdata),
		.o_ale     (o_ale),
		.o_rd_n    (o_rd_n),
		.o_wr_n    (o_wr_n),
		.o_inta_n  (o_inta_n),
		.o_iom_n   (o_iom_n),
		.o_s1      (o_s1),
		.o_s0      (o_s0),
		.o_addr_hi (o_addr_hi),
		.o_ad      (o_ad),
		.o_ad_oe   (o_ad_oe)
	);

	// ----------------------------------------
	// interrupts, beside the pipeline
	// ----------------------------------------

	intr_ctrl u_intr (
		.clk        (clk),
		.rst        (rst),
		.i_sim_wr   (i_sim_wr),
		.i_sim_data (i_sim_data),
		.i_ei       (i_ei),
		.i_di       (i_di),
		.i_ack_done (seq_ack_done),
		.i_trap     (i_trap),
		.i_rst75    (i_rst75),
		.i_rst65    (i_rst65),
		.i_rst55    (i_rst55),
		.i_sid      (i_sid),
		.o_int_req  (o_int_req),
		.o_int_vec  (o_int_vec),
		.o_rim      (o_rim),
		.o_sod      (o_sod)
	);

endmodule

`default_nettype wire

// ==== hw/bus_pin_drive.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus85_params.svh"

module bus_pin_drive (
	input  wire                           clk,
	input  wire                           rst,
	input  wire bus85_cycle_pkg::tstate_e i_state,
	input  wire bus85_cycle_pkg::stactl_t i_stactl,
	input  wire bus85_cycle_pkg::addr_t   i_addr,
	input  wire bus85_cycle_pkg::data_t   i_wdata,
	output logic                          o_ale,
	output logic                          o_rd_n,
	output logic                          o_wr_n,
	output logic                          o_inta_n,
	output logic                          o_iom_n,
	output logic                          o_s1,
	output logic                          o_s0,
	output bus85_cycle_pkg::data_t        o_addr_hi,
	output bus85_cycle_pkg::data_t        o_ad,
	output logic                          o_ad_oe
);
	import bus85_cycle_pkg::*;

	logic addr_ph; // address phase
	logic strobe;  // t2, tw, t3
	logic on_bus;  // t1 through t4

	assign addr_ph = (i_state == TS_T1);
	assign strobe  = (i_state == TS_T2) || (i_state == TS_TW) || (i_state == TS_T3);
	assign on_bus  = addr_ph || strobe || (i_state == TS_T4);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_ale    <= 1'b0;
			o_rd_n   <= 1'b1;
			o_wr_n   <= 1'b1;
			o_inta_n <= 1'b1;
			o_iom_n  <= 1'b1;
			o_s1     <= 1'b0;
			o_s0     <= 1'b0;
			o_ad_oe  <= 1'b0;
		end else begin
			o_ale    <= addr_ph;
			o_rd_n   <= !strobe || i_stactl[`BUS85_BIT_RD];
			o_wr_n   <= !strobe || i_stactl[`BUS85_BIT_WR];
			o_inta_n <= !strobe || i_stactl[`BUS85_BIT_INTA];
			o_ad_oe  <= addr_ph || (strobe && !i_stactl[`BUS85_BIT_WR]); // write data only
			if (on_bus) begin // status held while idle
				o_iom_n <= i_stactl[`BUS85_BIT_IOM];
				o_s1    <= i_stactl[`BUS85_BIT_S1];
				o_s0    <= i_stactl[`BUS85_BIT_S0];
			end
		end
	end

	// multiplexed low byte, high byte kept for the whole cycle
	always_ff @(posedge clk) begin
		o_ad <= addr_ph ? i_addr[`BUS85_DATA_W-1:0] : i_wdata;
		if (addr_ph)
			o_addr_hi <= i_addr[`BUS85_ADDR_W-1:`BUS85_DATA_W];
	end

endmodule

`default_nettype wire

// ==== hw/cycle_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus85_params.svh"

module cycle_decode (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               i_req,
	input  wire bus85_cycle_pkg::cycle_kind_e i_kind,
	input  wire bus85_cycle_pkg::addr_t       i_addr,
	input  wire bus85_cycle_pkg::data_t       i_wdata,
	input  wire                               i_take,
	output logic                              o_valid,
	output bus85_cycle_pkg::cycle_kind_e      o_kind,
	output bus85_cycle_pkg::stactl_t          o_stactl,
	output bus85_cycle_pkg::addr_t            o_addr,
	output bus85_cycle_pkg::data_t            o_wdata,
	output logic                              o_busy
);
	import bus85_cycle_pkg::*;

	logic    valid_q;
	stactl_t code_d;

	// kind to {inta_n, wr_n, rd_n, iom_n, s1, s0}
	always_comb begin
		case (i_kind)
			CYC_OF:  code_d = 6'b110011;
			CYC_MR:  code_d = 6'b110010;
			CYC_MW:  code_d = 6'b101001;
			CYC_DR:  code_d = 6'b110110;
			CYC_DW:  code_d = 6'b101101;
			CYC_INA: code_d = 6'b011111; // inta strobes, rd stays high
			default: code_d = '1;        // nothing strobed
		endcase
	end

	// one slot, emptied when the sequencer takes it
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (i_take) begin
			valid_q <= 1'b0;
		end else if (i_req) begin
			valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_req && !valid_q) begin // a request while full is dropped
			o_kind   <= i_kind;
			o_stactl <= code_d;
			o_addr   <= i_addr;
			o_wdata  <= i_wdata;
		end
	end

	assign o_valid = valid_q;
	assign o_busy  = valid_q;

endmodule

`default_nettype wire

// ==== hw/intr_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus85_params.svh"

module intr_ctrl (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         i_sim_wr,
	input  wire bus85_cycle_pkg::data_t i_sim_data,
	input  wire                         i_ei,
	input  wire                         i_di,
	input  wire                         i_ack_done,
	input  wire                         i_trap,
	input  wire                         i_rst75,
	input  wire                         i_rst65,
	input  wire                         i_rst55,
	input  wire                         i_sid,
	output logic                        o_int_req,
	output bus85_intr_pkg::int_vec_t    o_int_vec,
	output bus85_intr_pkg::rim_t        o_rim,
	output logic                        o_sod
);
	import bus85_intr_pkg::*;

	logic [1:0] sync1_q; // {trap, rst75}
	logic [1:0] sync2_q;
	logic [1:0] prev_q;
	logic [1:0] rise;
	logic       ltrap_q, l75_q;
	logic       ie_q, sod_q;
	logic       m75_q, m65_q, m55_q;
	logic       p_trap, p75, p65, p55;
	int_level_e win;
	int_vec_t   vec;

	// ----------------------------------------
	// pending and priority
	// ----------------------------------------

	assign rise   = sync2_q & ~prev_q;
	assign p_trap = ltrap_q && i_trap; // edge seen and level still high
	assign p75    = ie_q && !m75_q && l75_q;
	assign p65    = ie_q && !m65_q && i_rst65;
	assign p55    = ie_q && !m55_q && i_rst55;

	always_comb begin
		win = LVL_NONE;
		vec = '0;
		if (p_trap) begin
			win = LVL_TRAP;
			vec = `BUS85_VEC_TRAP;
		end else if (p75) begin
			win = LVL_R75;
			vec = `BUS85_VEC_R75;
		end else if (p65) begin
			win = LVL_R65;
			vec = `BUS85_VEC_R65;
		end else if (p55) begin
			win = LVL_R55;
			vec = `BUS85_VEC_R55;
		end
	end

	// ----------------------------------------
	// state
	// ----------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
			ltrap_q <= 1'b0;
			l75_q   <= 1'b0;
			ie_q    <= 1'b0;
			sod_q   <= 1'b0;
			{m75_q, m65_q, m55_q} <= 3'b111; // all masked
		end else begin
			sync1_q <= {i_trap, i_rst75};
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
			// a fresh edge beats a clear in the same clock
			if (rise[1])
				ltrap_q <= 1'b1;
			else if (i_ack_done && win == LVL_TRAP)
				ltrap_q <= 1'b0;
			if (rise[0])
				l75_q <= 1'b1;
			else if ((i_ack_done && win == LVL_R75) || (i_sim_wr && i_sim_data[4]))
				l75_q <= 1'b0;
			if (i_di || i_ack_done)
				ie_q <= 1'b0;
			else if (i_ei)
				ie_q <= 1'b1;
			if (i_sim_wr && i_sim_data[3])
				{m75_q, m65_q, m55_q} <= i_sim_data[2:0];
			if (i_sim_wr && i_sim_data[6])
				sod_q <= i_sim_data[7]; // serial out
		end
	end

	assign o_int_req = p_trap || p75 || p65 || p55;
	assign o_int_vec = vec;
	assign o_rim     = {i_sid, p75, p65, p55, ie_q, m75_q, m65_q, m55_q};
	assign o_sod     = sod_q;

endmodule

`default_nettype wire

// ==== hw/tstate_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus85_params.svh"

module tstate_seq (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               i_valid,
	input  wire bus85_cycle_pkg::cycle_kind_e i_kind,
	input  wire bus85_cycle_pkg::stactl_t     i_stactl,
	input  wire bus85_cycle_pkg::addr_t       i_addr,
	input  wire bus85_cycle_pkg::data_t       i_wdata,
	input  wire                               i_ready,
	input  wire bus85_cycle_pkg::data_t       i_ad,
	output logic                              o_take,
	output bus85_cycle_pkg::tstate_e          o_state,
	output bus85_cycle_pkg::stactl_t          o_stactl,
	output bus85_cycle_pkg::addr_t            o_addr,
	output bus85_cycle_pkg::data_t            o_wdata,
	output logic                              o_done,
	output bus85_cycle_pkg::data_t            o_rdata,
	output logic                              o_ack_done
);
	import bus85_cycle_pkg::*;

	tstate_e     state_q;
	tstate_e     state_d;
	logic        armed_q; // item loaded from idle, T1 follows
	logic        last_t;
	logic        take;
	logic        is_read;
	cycle_kind_e kind_q;
	stactl_t     stactl_q;
	addr_t       addr_q;
	data_t       wdata_q;

	// ----------------------------------------
	// next state
	// ----------------------------------------

	// T3 ends the cycle except for opcode fetch, which runs T4
	assign last_t = (state_q == TS_T4) || (state_q == TS_T3 && kind_q != CYC_OF);
	assign take   = i_valid && ((state_q == TS_IDLE && !armed_q) || last_t);

	always_comb begin
		state_d = state_q;
		case (state_q)
			TS_IDLE: begin
				if (armed_q)
					state_d = TS_T1;
			end
			TS_T1: state_d = TS_T2;
			TS_T2, TS_TW: begin
				state_d = i_ready ? TS_T3 : TS_TW; // low ready adds one TW
			end
			TS_T3: begin
				if (kind_q == CYC_OF)
					state_d = TS_T4;
				else
					state_d = i_valid ? TS_T1 : TS_IDLE;
			end
			TS_T4: state_d = i_valid ? TS_T1 : TS_IDLE;
			default: state_d = TS_IDLE;
		endcase
	end

	// ----------------------------------------
	// registers
	// ----------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= TS_IDLE;
			armed_q <= 1'b0;
		end else begin
			state_q <= state_d;
			armed_q <= take && (state_q == TS_IDLE);
		end
	end

	assign is_read = !stactl_q[`BUS85_BIT_RD] || !stactl_q[`BUS85_BIT_INTA];

	always_ff @(posedge clk) begin
		if (take) begin
			kind_q   <= i_kind;
			stactl_q <= i_stactl;
			addr_q   <= i_addr;
			wdata_q  <= i_wdata;
		end
		if (state_q == TS_T3 && is_read)
			o_rdata <= i_ad; // end of T3
	end

	// pin stage registers these, so it sees the coming state and item
	assign o_take     = take;
	assign o_state    = state_d;
	assign o_stactl   = take ? i_stactl : stactl_q;
	assign o_addr     = take ? i_addr : addr_q;
	assign o_wdata    = take ? i_wdata : wdata_q;
	assign o_done     = (state_q == TS_T3);
	assign o_ack_done = o_done && (kind_q == CYC_INA);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_bus85 -f filelist.f
out=$(./obj_dir/Vtb_bus85)
echo "$out"
echo "$out" | grep -q '\*\*\* PASSED \*\*\*'
